/* tb.f */
+incdir+bench
logic/memCardPkg.sv
logic/memCardCtrl.sv
logic/cardStore.sv
logic/frameCheck.sv
logic/replyGen.sv
logic/memCardTop.sv
bench/memCardTb.sv

/* Bender.yml */
package:
  name: memcard

sources:
  - logic/memCardPkg.sv
  - logic/memCardCtrl.sv
  - logic/cardStore.sv
  - logic/frameCheck.sv
  - logic/replyGen.sv
  - logic/memCardTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/memCardTb.sv

/* bench/frameTable.svh */
typedef struct packed {
	logic [7:0] kind;      // Command byte sent after select
	logic [7:0] adrHi;
	logic [7:0] adrLo;
	logic       corrupt;   // Flip the write checksum
	logic [7:0] status;    // Last reply of the frame
} frameRow;

localparam int numRows = 12;

frameRow rows [0:numRows-1];

task automatic loadTable;
	// Command, address high, address low, corrupt, last reply
	rows[0]  = {8'h52, 8'h00, 8'h00, 1'b0, 8'h47};   // Preloaded sector, fresh card
	rows[1]  = {8'h57, 8'h00, 8'h01, 1'b0, 8'h47};
	rows[2]  = {8'h52, 8'h00, 8'h01, 1'b0, 8'h47};
	rows[3]  = {8'h57, 8'h00, 8'h02, 1'b1, 8'h4E};   // Data still stored
	rows[4]  = {8'h52, 8'h00, 8'h02, 1'b0, 8'h47};
	rows[5]  = {8'h57, 8'h04, 8'h00, 1'b0, 8'hFF};   // Aliases sector 0 if not blocked
	rows[6]  = {8'h52, 8'h00, 8'h00, 1'b0, 8'h47};
	rows[7]  = {8'h53, 8'h00, 8'h00, 1'b0, 8'hFF};   // Get-ID not served
	rows[8]  = {8'h33, 8'h00, 8'h00, 1'b0, 8'hFF};
	rows[9]  = {8'h57, 8'h03, 8'hFF, 1'b0, 8'h47};   // Last sector
	rows[10] = {8'h52, 8'h03, 8'hFF, 1'b0, 8'h47};
	rows[11] = {8'h52, 8'h00, 8'h03, 1'b0, 8'h47};
endtask

/* bench/memCardTb.sv */
module memCardTb;
	localparam int          sectorBits    = 10;
	localparam int          blockBytes    = 128;
	localparam int          imageBytes    = 2**(sectorBits + 7);
	localparam int          timeoutCycles = 20;
	localparam logic [16:0] pokeAdr       = 17'h00085;   // Sector 1, byte 5

	logic               clk;
	logic               rstN;
	logic               rxValid;
	logic [7:0]         rxData;
	memCardPkg::hostReq host;
	logic               txValid;
	logic [7:0]         txData;
	logic               hostReady;
	logic [7:0]         hostRData;

	logic [7:0]           image [0:imageBytes-1];   // Card image model
	memCardPkg::cardFlags flagsModel;
	logic                 pokeHost;   // Host write during the next strobe
	integer               seed;

	`include "frameTable.svh"

	memCardTop u_dut (
		.i_clk      (clk),
		.i_rstN     (rstN),
		.i_rxValid  (rxValid),
		.i_rxData   (rxData),
		.i_host     (host),
		.o_txValid  (txValid),
		.o_txData   (txData),
		.o_hostReady(hostReady),
		.o_hostRData(hostRData)
	);

	always #20 clk = ~clk;

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic checkValue(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s is 0x%02h, expected 0x%02h", $time, name, actual,
				expected);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	// Depends on every address bit
	function automatic logic [7:0] fillByte(input logic [16:0] adr);
		return adr[7:0] ^ adr[15:8] ^ {7'd0, adr[16]} ^ 8'h3C;
	endfunction

	// --------------------------------------------------
	// Link byte and host access
	// --------------------------------------------------
	task automatic sendByte(input logic [7:0] data, input logic [7:0] expected);
		int waited;
		@(negedge clk);
		rxValid = 1'b1;
		rxData  = data;
		if (pokeHost) begin
			host.adr   = pokeAdr;
			host.write = 1'b1;
			host.wData = ~image[pokeAdr];   // Must be dropped by the store
		end
		@(posedge clk);
		checkValue("o_hostReady", hostReady, 8'h00);
		@(negedge clk);
		rxValid    = 1'b0;
		host.write = 1'b0;
		waited     = 1;
		while (txValid !== 1'b1) begin
			if (waited >= timeoutCycles) begin
				reportTimeout("the reply strobe o_txValid");
			end
			@(negedge clk);
			waited++;
		end
		checkValue("o_txValid delay", 8'(waited), 8'd2);
		checkValue("o_txData", txData, expected);
		@(negedge clk);   // Keeps strobes 4 cycles apart
	endtask

	task automatic waitHostReady;
		int waited;
		waited = 0;
		@(posedge clk);
		while (hostReady !== 1'b1) begin
			waited++;
			if (waited > timeoutCycles) begin
				reportTimeout("o_hostReady");
			end
			@(posedge clk);
		end
	endtask

	task automatic hostWrite(input logic [16:0] adr, input logic [7:0] data);
		@(negedge clk);
		host.adr   = adr;
		host.write = 1'b1;
		host.wData = data;
		waitHostReady();
		@(negedge clk);
		host.write = 1'b0;
		image[adr] = data;
	endtask

	task automatic hostRead(input logic [16:0] adr);
		@(negedge clk);
		host.adr   = adr;
		host.write = 1'b0;
		waitHostReady();
		@(negedge clk);   // One cycle after acceptance
		checkValue("o_hostRData", hostRData, image[adr]);
	endtask

	// --------------------------------------------------
	// Frames
	// --------------------------------------------------
	task automatic sendAddress(input logic [7:0] adrHi, input logic [7:0] adrLo);
		sendByte(8'h00, 8'h5A);
		sendByte(8'h00, 8'h5D);
		sendByte(adrHi, 8'h00);
		sendByte(adrLo, 8'h00);
	endtask

	task automatic runFrame(input frameRow row);
		logic [7:0]  chk;
		logic [7:0]  data;
		logic [16:0] base;
		logic        badSector;
		integer      rnd;
		base      = {row.adrHi[1:0], row.adrLo, 7'd0};
		badSector = row.adrHi[7:2] != 6'd0;   // Sector number of 1024 or more
		chk       = row.adrHi ^ row.adrLo;
		sendByte(8'h81, 8'hFF);
		sendByte(row.kind, {3'b000, flagsModel, 2'b00});
		flagsModel.error = 1'b0;
		if (row.kind == 8'h52) begin
			sendAddress(row.adrHi, row.adrLo);
			sendByte(8'h00, 8'h5C);
			sendByte(8'h00, 8'h5D);
			sendByte(8'h00, row.adrHi);
			sendByte(8'h00, row.adrLo);
			for (int i = 0; i < blockBytes; i++) begin
				sendByte(8'h00, image[base + i]);
				chk = chk ^ image[base + i];
			end
			sendByte(8'h00, chk);
			sendByte(8'h00, row.status);
		end else if (row.kind == 8'h57) begin
			sendAddress(row.adrHi, row.adrLo);
			for (int i = 0; i < blockBytes; i++) begin
				rnd  = $random(seed);
				data = rnd[7:0];
				sendByte(data, 8'h00);
				chk = chk ^ data;
				if (!badSector) begin
					image[base + i] = data;
				end
			end
			sendByte(row.corrupt ? ~chk : chk, 8'h00);
			sendByte(8'h00, 8'h5C);
			sendByte(8'h00, 8'h5D);
			sendByte(8'h00, row.status);
			if (row.status == 8'h47) begin
				flagsModel.fresh = 1'b0;
			end else begin
				flagsModel.error = 1'b1;
			end
		end else begin
			pokeHost = 1'b1;   // Card is idle again, host write lands in a strobe
			sendByte(8'h00, row.status);
			pokeHost = 1'b0;
		end
	endtask

	initial begin
		integer rnd;
		clk      = 1'b0;
		rstN     = 1'b0;
		rxValid  = 1'b0;
		rxData   = 8'h00;
		host     = '0;
		pokeHost = 1'b0;
		seed     = 32'h1a2a9770;
		flagsModel.unknown = 1'b1;
		flagsModel.fresh   = 1'b1;
		flagsModel.error   = 1'b0;
		loadTable();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		checkValue("o_txValid", txValid, 8'h00);
		checkValue("o_txData", txData, 8'hFF);

		// Sectors 0 to 3 through the host port
		for (int a = 0; a < 4 * blockBytes; a++) begin
			hostWrite(17'(a), fillByte(17'(a)));
		end

		for (int r = 0; r < numRows; r++) begin
			runFrame(rows[r]);
		end

		// Card-written sector, poke address included
		for (int i = 0; i < blockBytes; i++) begin
			hostRead(17'(blockBytes + i));
		end
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			hostRead({8'd0, rnd[8:0]});
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* logic/memCardTop.sv */
module memCardTop #(
	parameter int sectorBits = 10
) (
	input  logic               i_clk,
	input  logic               i_rstN,
	input  logic               i_rxValid,
	input  logic [7:0]         i_rxData,
	input  memCardPkg::hostReq i_host,
	output logic               o_txValid,
	output logic [7:0]         o_txData,
	output logic               o_hostReady,
	output logic [7:0]         o_hostRData
);
	memCardPkg::storeReq    store;
	memCardPkg::replyKind   reply;
	memCardPkg::cardFlags   flags;
	memCardPkg::writeStatus status;
	logic [sectorBits-1:0]  sector;
	logic [9:0]             replySector;
	logic [7:0]             rData;
	logic [7:0]             chkSum;
	logic                   chkClear;
	logic                   chkAddRx;
	logic                   chkAddMem;
	logic                   chkMatch;

	assign replySector = 10'(sector);   // Echo is always two address bytes
	assign o_hostRData = rData;

	// --------------------------------------------------
	// Sequencer and datapath
	// --------------------------------------------------
	memCardCtrl #(.sectorBits(sectorBits)) u_ctrl (
		.i_clk, .i_rstN, .i_rxValid, .i_rxData,
		.i_chkMatch (chkMatch),
		.o_store    (store),
		.o_reply    (reply),
		.o_flags    (flags),
		.o_status   (status),
		.o_sector   (sector),
		.o_chkClear (chkClear),
		.o_chkAddRx (chkAddRx),
		.o_chkAddMem(chkAddMem)
	);

	cardStore #(.sectorBits(sectorBits)) u_store (
		.i_clk, .i_rxData, .i_host, .o_hostReady,
		.i_store(store),
		.o_rData(rData)
	);

	frameCheck u_check (
		.i_clk, .i_rstN, .i_rxData, .i_rxValid,
		.i_rData (rData),
		.i_clear (chkClear),
		.i_addRx (chkAddRx),
		.i_addMem(chkAddMem),
		.o_chkSum(chkSum),
		.o_chkMatch(chkMatch)
	);

	replyGen u_reply (
		.i_clk, .i_rstN, .i_rxValid, .o_txValid, .o_txData,
		.i_reply (reply),
		.i_flags (flags),
		.i_status(status),
		.i_sector(replySector),
		.i_rData (rData),
		.i_chkSum(chkSum)
	);

endmodule

/* logic/replyGen.sv */
module replyGen (
	input  logic                   i_clk,
	input  logic                   i_rstN,
	input  logic                   i_rxValid,
	input  memCardPkg::replyKind   i_reply,
	input  memCardPkg::cardFlags   i_flags,
	input  memCardPkg::writeStatus i_status,
	input  logic [9:0]             i_sector,
	input  logic [7:0]             i_rData,
	input  logic [7:0]             i_chkSum,
	output logic                   o_txValid,
	output logic [7:0]             o_txData
);
	memCardPkg::replyKind   kind;
	memCardPkg::cardFlags   flags;
	memCardPkg::writeStatus status;
	logic [9:0]             sector;
	logic [7:0]             chkSum;
	logic                   pending;
	logic [7:0]             txByte;

	// --------------------------------------------------
	// Stage 1, capture at the strobe
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			pending <= 1'b0;
			kind    <= memCardPkg::repIdle;
		end else begin
			pending <= i_rxValid;
			if (i_rxValid) begin
				kind <= i_reply;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rxValid) begin
			flags  <= i_flags;
			status <= i_status;
			sector <= i_sector;
			chkSum <= i_chkSum;
		end
	end

	always_comb begin
		case (kind)
			memCardPkg::repFlags:   txByte = {3'b000, flags, 2'b00};
			memCardPkg::repId1:     txByte = memCardPkg::idByte1;
			memCardPkg::repId2:     txByte = memCardPkg::idByte2;
			memCardPkg::repZero:    txByte = 8'h00;
			memCardPkg::repAck1:    txByte = memCardPkg::ackByte1;
			memCardPkg::repAck2:    txByte = memCardPkg::ackByte2;
			memCardPkg::repAdrHi:   txByte = {6'd0, sector[9:8]};
			memCardPkg::repAdrLo:   txByte = sector[7:0];
			memCardPkg::repMemData: txByte = i_rData;   // Valid in this cycle only
			memCardPkg::repChk:     txByte = chkSum;
			memCardPkg::repGood:    txByte = memCardPkg::statGood;
			memCardPkg::repStatus:  txByte = status;
			default:                txByte = 8'hFF;
		endcase
	end

	// Stage 2, byte out with its strobe
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_txValid <= 1'b0;
			o_txData  <= 8'hFF;
		end else begin
			o_txValid <= pending;
			if (pending) begin
				o_txData <= txByte;   // Held until the next reply
			end
		end
	end

endmodule

/* logic/frameCheck.sv */
module frameCheck (
	input  logic       i_clk,
	input  logic       i_rstN,
	input  logic [7:0] i_rxData,
	input  logic       i_rxValid,
	input  logic [7:0] i_rData,
	input  logic       i_clear,
	input  logic       i_addRx,
	input  logic       i_addMem,
	output logic [7:0] o_chkSum,
	output logic       o_chkMatch
);
	logic memAdd;   // Read data arrives a cycle after the strobe

	// --------------------------------------------------
	// XOR accumulator
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			o_chkSum <= 8'h00;
			memAdd   <= 1'b0;
		end else begin
			memAdd <= i_rxValid && i_addMem;
			if (i_rxValid && i_clear) begin
				o_chkSum <= 8'h00;
			end else if (i_rxValid && i_addRx) begin
				o_chkSum <= o_chkSum ^ i_rxData;    // Address and write data
			end else if (memAdd) begin
				o_chkSum <= o_chkSum ^ i_rData;     // Sector read data
			end
		end
	end

	// Sampled by the sequencer on the checksum byte
	assign o_chkMatch = i_rxData == o_chkSum;

endmodule

/* logic/cardStore.sv */
module cardStore #(
	parameter int sectorBits = 10
) (
	input  logic                i_clk,
	input  logic [7:0]          i_rxData,
	input  memCardPkg::storeReq i_store,
	input  memCardPkg::hostReq  i_host,
	output logic [7:0]          o_rData,
	output logic                o_hostReady
);
	// Sector number followed by byte index
	localparam int adrBits = sectorBits + $clog2(memCardPkg::blockBytes);

	logic [7:0]         mem [0:2**adrBits-1];
	logic [adrBits-1:0] workAdr;
	logic [adrBits-1:0] rdAdr;
	logic [7:0]         workData;
	logic               workWrite;

	// --------------------------------------------------
	// Link over host arbitration
	// --------------------------------------------------
	assign o_hostReady = !i_store.valid;   // Host must retry in strobe cycles

	always_comb begin
		if (i_store.valid) begin
			workAdr   = i_store.adr[adrBits-1:0];
			workData  = i_rxData;
			workWrite = i_store.write;
		end else begin
			workAdr   = i_host.adr[adrBits-1:0];
			workData  = i_host.wData;
			workWrite = i_host.write;
		end
	end

	always_ff @(posedge i_clk) begin
		if (workWrite) begin
			mem[workAdr] <= workData;
		end
		rdAdr <= workAdr;   // Read lands one cycle after the request
	end

	assign o_rData = mem[rdAdr];

	// Host stays locked out whenever the link writes
	property hostHeldOff;
		@(posedge i_clk)
		i_store.write |-> !o_hostReady;
	endproperty
	assert property (hostHeldOff)
		else $error("Host access accepted during a link write");

endmodule

/* logic/memCardCtrl.sv */
module memCardCtrl #(
	parameter int sectorBits = 10
) (
	input  logic                   i_clk,
	input  logic                   i_rstN,
	input  logic                   i_rxValid,
	input  logic [7:0]             i_rxData,
	input  logic                   i_chkMatch,
	output memCardPkg::storeReq    o_store,
	output memCardPkg::replyKind   o_reply,
	output memCardPkg::cardFlags   o_flags,
	output memCardPkg::writeStatus o_status,
	output logic [sectorBits-1:0]  o_sector,
	output logic                   o_chkClear,
	output logic                   o_chkAddRx,
	output logic                   o_chkAddMem
);
	localparam logic [6:0] lastIndex = 7'(memCardPkg::blockBytes - 1);

	memCardPkg::cardState state;
	memCardPkg::cardState stateNext;
	memCardPkg::cardCmd   cmd;
	logic [6:0]           index;
	logic [7:0]           adrHi;
	logic [15:0]          adrFull;
	logic                 badAdr;
	logic                 badSector;   // Held until the next address

	assign cmd     = memCardPkg::cardCmd'(i_rxData);
	assign adrFull = {adrHi, i_rxData};   // Only meaningful on the low byte
	assign badAdr  = (adrFull >> sectorBits) != 16'd0;

	// --------------------------------------------------
	// One state step per received byte
	// --------------------------------------------------
	always_comb begin
		stateNext = memCardPkg::idle;
		case (state)
			memCardPkg::idle: begin
				if (cmd == memCardPkg::cmdSelect) begin
					stateNext = memCardPkg::waitCmd;
				end
			end
			memCardPkg::waitCmd: begin
				case (cmd)
					memCardPkg::cmdRead:  stateNext = memCardPkg::rdId1;
					memCardPkg::cmdWrite: stateNext = memCardPkg::wrId1;
					default:              stateNext = memCardPkg::idle;  // Get-ID as well
				endcase
			end
			memCardPkg::rdId1:    stateNext = memCardPkg::rdId2;
			memCardPkg::rdId2:    stateNext = memCardPkg::rdAdrHi;
			memCardPkg::rdAdrHi:  stateNext = memCardPkg::rdAdrLo;
			memCardPkg::rdAdrLo:  stateNext = memCardPkg::rdAck1;
			memCardPkg::rdAck1:   stateNext = memCardPkg::rdAck2;
			memCardPkg::rdAck2:   stateNext = memCardPkg::rdEchoHi;
			memCardPkg::rdEchoHi: stateNext = memCardPkg::rdEchoLo;
			memCardPkg::rdEchoLo: stateNext = memCardPkg::rdData;
			memCardPkg::rdData: begin
				stateNext = (index == lastIndex) ? memCardPkg::rdChk : memCardPkg::rdData;
			end
			memCardPkg::rdChk:    stateNext = memCardPkg::rdEnd;
			memCardPkg::wrId1:    stateNext = memCardPkg::wrId2;
			memCardPkg::wrId2:    stateNext = memCardPkg::wrAdrHi;
			memCardPkg::wrAdrHi:  stateNext = memCardPkg::wrAdrLo;
			memCardPkg::wrAdrLo:  stateNext = memCardPkg::wrData;
			memCardPkg::wrData: begin
				stateNext = (index == lastIndex) ? memCardPkg::wrChk : memCardPkg::wrData;
			end
			memCardPkg::wrChk:    stateNext = memCardPkg::wrAck1;
			memCardPkg::wrAck1:   stateNext = memCardPkg::wrAck2;
			memCardPkg::wrAck2:   stateNext = memCardPkg::wrEnd;
			default:              stateNext = memCardPkg::idle;  // rdEnd and wrEnd too
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rstN) begin
		if (!i_rstN) begin
			state     <= memCardPkg::idle;
			index     <= '0;
			badSector <= 1'b0;
			o_flags   <= '{unknown: 1'b1, fresh: 1'b1, error: 1'b0};
			o_status  <= memCardPkg::statGood;
		end else if (i_rxValid) begin
			state <= stateNext;
			case (state)
				memCardPkg::waitCmd: o_flags.error <= 1'b0;
				memCardPkg::rdAdrLo, memCardPkg::wrAdrLo: begin
					index     <= '0;
					badSector <= badAdr;
					o_status  <= badAdr ? memCardPkg::statBadSector : memCardPkg::statGood;
					if (badAdr) begin
						o_flags.error <= 1'b1;
					end
				end
				memCardPkg::rdData, memCardPkg::wrData: index <= index + 7'd1;
				memCardPkg::wrChk: begin
					// Sector fault outranks the checksum
					if (!i_chkMatch && !badSector) begin
						o_status      <= memCardPkg::statBadChk;
						o_flags.error <= 1'b1;
					end
				end
				memCardPkg::wrEnd: begin
					if (o_status == memCardPkg::statGood) begin
						o_flags.fresh <= 1'b0;
					end
				end
				default: ;
			endcase
		end
	end

	// Address capture
	always_ff @(posedge i_clk) begin
		if (i_rxValid) begin
			if (state == memCardPkg::rdAdrHi || state == memCardPkg::wrAdrHi) begin
				adrHi <= i_rxData;
			end
			if (state == memCardPkg::rdAdrLo || state == memCardPkg::wrAdrLo) begin
				o_sector <= adrFull[sectorBits-1:0];
			end
		end
	end

	// --------------------------------------------------
	// Memory request, reply kind and checksum control
	// --------------------------------------------------
	always_comb begin
		o_store       = '0;
		o_store.valid = i_rxValid;   // Link owns the memory on every strobe
		o_store.write = i_rxValid && state == memCardPkg::wrData && !badSector;
		o_store.adr[sectorBits+6:0] = {o_sector, index};
	end

	always_comb begin
		case (state)
			memCardPkg::waitCmd:  o_reply = memCardPkg::repFlags;
			memCardPkg::rdId1,
			memCardPkg::wrId1:    o_reply = memCardPkg::repId1;
			memCardPkg::rdId2,
			memCardPkg::wrId2:    o_reply = memCardPkg::repId2;
			memCardPkg::rdAck1,
			memCardPkg::wrAck1:   o_reply = memCardPkg::repAck1;
			memCardPkg::rdAck2,
			memCardPkg::wrAck2:   o_reply = memCardPkg::repAck2;
			memCardPkg::rdAdrHi, memCardPkg::rdAdrLo, memCardPkg::wrAdrHi,
			memCardPkg::wrAdrLo, memCardPkg::wrData, memCardPkg::wrChk: begin
				o_reply = memCardPkg::repZero;
			end
			memCardPkg::rdEchoHi: o_reply = memCardPkg::repAdrHi;
			memCardPkg::rdEchoLo: o_reply = memCardPkg::repAdrLo;
			memCardPkg::rdData:   o_reply = memCardPkg::repMemData;
			memCardPkg::rdChk:    o_reply = memCardPkg::repChk;
			memCardPkg::rdEnd:    o_reply = memCardPkg::repGood;
			memCardPkg::wrEnd:    o_reply = memCardPkg::repStatus;
			default:              o_reply = memCardPkg::repIdle;
		endcase
	end

	assign o_chkClear  = state == memCardPkg::waitCmd;
	assign o_chkAddRx  = state inside {memCardPkg::rdAdrHi, memCardPkg::rdAdrLo,
		memCardPkg::wrAdrHi, memCardPkg::wrAdrLo, memCardPkg::wrData};
	assign o_chkAddMem = state == memCardPkg::rdData;

	// Reply pipeline and checksum add need the gap
	property strobeSpacing;
		@(posedge i_clk) disable iff (!i_rstN)
		i_rxValid |=> !i_rxValid [*2];
	endproperty
	assert property (strobeSpacing)
		else $error("Link strobes closer than 3 cycles");

endmodule

/* logic/memCardPkg.sv */
package memCardPkg;

	// --------------------------------------------------
	// Frame sequencer states
	// --------------------------------------------------
	typedef enum logic [4:0] {
		idle,
		waitCmd,
		rdId1,
		rdId2,
		rdAdrHi,
		rdAdrLo,
		rdAck1,
		rdAck2,
		rdEchoHi,
		rdEchoLo,
		rdData,
		rdChk,
		rdEnd,
		wrId1,
		wrId2,
		wrAdrHi,
		wrAdrLo,
		wrData,
		wrChk,
		wrAck1,
		wrAck2,
		wrEnd
	} cardState;

	typedef enum logic [7:0] {
		cmdSelect = 8'h81,
		cmdRead   = 8'h52,  // 'R'
		cmdWrite  = 8'h57,  // 'W'
		cmdGetId  = 8'h53   // 'S'
	} cardCmd;

	// Last byte of a write frame
	typedef enum logic [7:0] {
		statGood      = 8'h47,  // 'G'
		statBadChk    = 8'h4E,  // 'N'
		statBadSector = 8'hFF
	} writeStatus;

	typedef enum logic [3:0] {
		repIdle,
		repFlags,
		repId1,
		repId2,
		repZero,
		repAck1,
		repAck2,
		repAdrHi,
		repAdrLo,
		repMemData,
		repChk,
		repGood,
		repStatus
	} replyKind;

	// Sits at bits 4..2 of the flags byte
	typedef struct packed {
		logic unknown;
		logic fresh;
		logic error;
	} cardFlags;

	localparam int              blockBytes = 128;
	localparam int              maxAdrBits = 17;
	localparam logic [7:0]      idByte1    = 8'h5A;
	localparam logic [7:0]      idByte2    = 8'h5D;
	localparam logic [7:0]      ackByte1   = 8'h5C;
	localparam logic [7:0]      ackByte2   = 8'h5D;

	typedef struct packed {
		logic [maxAdrBits-1:0] adr;
		logic                  write;
		logic [7:0]            wData;
	} hostReq;

	// Sequencer access, address is sector then index
	typedef struct packed {
		logic                  valid;
		logic                  write;
		logic [maxAdrBits-1:0] adr;
	} storeReq;

endpackage
